/* chipset_config.svh */
/* widths, register offsets and interrupt bit numbers of the chip-bus core
   included by the package and by every module that decodes registers */
`ifndef CHIPSET_CONFIG_SVH
`define CHIPSET_CONFIG_SVH

`define CHIP_AW 12 // chip ram word address, 4K words
`define CPU_AW 13 // cpu word address, msb picks register space
`define DW 16

// custom register word offsets
`define REG_DMASRC 3'd0
`define REG_DMADST 3'd1
`define REG_DMALEN 3'd2
`define REG_DMACON 3'd3
`define REG_INTENA 3'd4
`define REG_INTREQ 3'd5
`define REG_INTENAR 3'd6
`define REG_INTREQR 3'd7

// interrupt and control bits
`define INT_MASTER 14 // master enable in intena
`define INT_SETCLR 15 // 1 sets, 0 clears
`define INT_DMA 3 // block copy finished
`define INT_EXT2 2 // external level 2 source
`define DMA_START 0 // dmacon start strobe

`endif

/* chipset_pkg.sv */
/* shared types of the chip-bus core
   imported by the RTL and the testbench */
`default_nettype none
`include "chipset_config.svh"

package chipset_pkg;

	// ----------------------------------------
	// bus widths
	typedef logic [`CHIP_AW-1:0] chip_addr_t; // chip ram word address
	typedef logic [`CPU_AW-1:0] cpu_addr_t; // cpu word address
	typedef logic [`DW-1:0] word_t;
	typedef logic [1:0] byte_en_t; // [1] upper byte, [0] lower byte

	// ----------------------------------------
	// custom register side
	typedef logic [2:0] reg_addr_t; // register word offset
	typedef logic [2:0] ipl_t; // encoded interrupt level
	typedef logic [14:0] int_bits_t; // intena / intreq without set-clr bit

	// last owner of chip ram
	typedef enum logic [1:0] {
		IDLE,
		DMA_SLOT,
		CPU_SLOT
	} arb_state_t;

endpackage

`default_nettype wire

/* chip_bus_if.sv */
/* chip ram link between a master and the arbiter or the arbiter and the ram,
   plus the control link from the custom registers to the copy channel */
`timescale 1ns/1ps
`default_nettype none

interface chip_bus_if;
	import chipset_pkg::*;

	logic       req; // level, held until gnt
	logic       gnt; // one-cycle pulse
	chip_addr_t addr;
	logic       we;
	byte_en_t   be;
	word_t      wdata;
	word_t      rdata;
	logic       rvalid; // one cycle after a read gnt

	modport requester (output req, addr, we, be, wdata, input gnt, rdata, rvalid);
	modport arbiter (input req, addr, we, be, wdata, output gnt, rdata, rvalid);
	modport host (output req, gnt, addr, we, be, wdata, input rdata, rvalid); // arbiter to ram
	modport ram (input gnt, addr, we, be, wdata, output rdata, rvalid);
endinterface

interface dma_ctrl_if;
	import chipset_pkg::*;

	chip_addr_t src;
	chip_addr_t dst;
	chip_addr_t len; // words to copy
	logic       start; // pulse
	logic       done; // pulse

	modport regs (output src, dst, len, start, input done);
	modport channel (input src, dst, len, start, output done);
endinterface

`default_nettype wire

/* cpu_bridge.sv */
/* 68k style bus bridge with held address strobe and one-cycle dtack
   steers each cycle to chip ram through the arbiter or to the custom registers */
`timescale 1ns/1ps
`default_nettype none
`include "chipset_config.svh"

module cpu_bridge (
	input  wire logic                  clk,
	input  wire logic                  reset,
	input  wire logic                  cpu_as_i, // held for the whole cycle
	input  wire logic                  cpu_we_i,
	input  wire chipset_pkg::cpu_addr_t cpu_addr_i,
	input  wire chipset_pkg::byte_en_t  cpu_be_i,
	input  wire chipset_pkg::word_t     cpu_wdata_i,
	output chipset_pkg::word_t          cpu_rdata_o,
	output logic                        cpu_dtack_o,
	chip_bus_if.requester               bus,
	output logic                        reg_sel_o,
	output logic                        reg_we_o,
	output chipset_pkg::reg_addr_t      reg_addr_o,
	output chipset_pkg::word_t          reg_wdata_o,
	input  wire chipset_pkg::word_t     reg_rdata_i
);
	import chipset_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_RAM, S_HOLD} br_state_t;

	br_state_t state_q;
	logic      is_reg; // register space
	logic      new_cyc; // fresh strobe while idle

	assign is_reg  = cpu_addr_i[`CPU_AW-1];
	assign new_cyc = (state_q == S_IDLE) && cpu_as_i;

	// register strobe lasts the first cycle only
	assign reg_sel_o   = new_cyc && is_reg;
	assign reg_we_o    = cpu_we_i;
	assign reg_addr_o  = cpu_addr_i[2:0];
	assign reg_wdata_o = cpu_wdata_i;

	// ----------------------------------------
	// cycle control
	always_ff @(posedge clk) begin
		if (reset) begin
			state_q     <= S_IDLE;
			bus.req     <= 1'b0;
			cpu_dtack_o <= 1'b0;
		end else begin
			cpu_dtack_o <= 1'b0; // pulse only
			case (state_q)
				S_IDLE: begin
					if (reg_sel_o) begin
						cpu_dtack_o <= 1'b1; // register access ends next cycle
						state_q     <= S_HOLD;
					end else if (new_cyc) begin
						bus.req <= 1'b1;
						state_q <= S_RAM;
					end
				end
				S_RAM: begin
					if (bus.gnt) begin
						bus.req <= 1'b0;
						if (bus.we) begin
							cpu_dtack_o <= 1'b1; // write done on its gnt
							state_q     <= S_HOLD;
						end
					end
					if (bus.rvalid) begin
						cpu_dtack_o <= 1'b1;
						state_q     <= S_HOLD;
					end
				end
				S_HOLD: if (!cpu_as_i) state_q <= S_IDLE; // wait for strobe to drop
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// ram request payload and returned data
	always_ff @(posedge clk) begin
		if (new_cyc && !is_reg) begin
			bus.addr  <= cpu_addr_i[`CHIP_AW-1:0];
			bus.we    <= cpu_we_i;
			bus.be    <= cpu_be_i;
			bus.wdata <= cpu_wdata_i;
		end
		if (reg_sel_o)
			cpu_rdata_o <= reg_rdata_i;
		else if (bus.rvalid && state_q == S_RAM)
			cpu_rdata_o <= bus.rdata;
	end

endmodule

`default_nettype wire

/* blit_dma.sv */
/* block copy channel, one word read then written back per step
   started by the custom registers, reports done when the last word is written */
`timescale 1ns/1ps
`default_nettype none

module blit_dma (
	input wire logic    clk,
	input wire logic    reset,
	dma_ctrl_if.channel ctrl,
	chip_bus_if.requester bus
);
	import chipset_pkg::*;

	typedef enum logic [1:0] {D_IDLE, D_RD, D_WAIT, D_WR} dma_state_t;

	dma_state_t state_q;
	chip_addr_t src_q; // next source word
	chip_addr_t dst_q; // next destination word
	chip_addr_t cnt_q; // words left
	word_t      data_q; // word in flight
	logic       done_q;

	// request comes straight from the state
	assign bus.req   = (state_q == D_RD) || (state_q == D_WR);
	assign bus.we    = (state_q == D_WR);
	assign bus.addr  = (state_q == D_WR) ? dst_q : src_q;
	assign bus.be    = 2'b11; // always full words
	assign bus.wdata = data_q;
	assign ctrl.done = done_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= D_IDLE;
			cnt_q   <= '0;
			done_q  <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state_q)
				D_IDLE: begin
					if (ctrl.start) begin
						if (ctrl.len == '0) begin
							done_q <= 1'b1; // nothing to copy
						end else begin
							src_q   <= ctrl.src;
							dst_q   <= ctrl.dst;
							cnt_q   <= ctrl.len;
							state_q <= D_RD;
						end
					end
				end
				D_RD: if (bus.gnt) state_q <= D_WAIT;
				D_WAIT: begin
					if (bus.rvalid) begin
						data_q  <= bus.rdata;
						state_q <= D_WR;
					end
				end
				D_WR: begin
					if (bus.gnt) begin
						src_q <= src_q + 1'b1;
						dst_q <= dst_q + 1'b1;
						cnt_q <= cnt_q - 1'b1;
						if (cnt_q == chip_addr_t'(1)) begin
							done_q  <= 1'b1; // last word written
							state_q <= D_IDLE;
						end else begin
							state_q <= D_RD;
						end
					end
				end
				default: state_q <= D_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* chip_arbiter.sv */
/* chip ram arbiter between the copy channel and the cpu bridge
   one grant per clock, alternating when both ask, dma first after idle */
`timescale 1ns/1ps
`default_nettype none

module chip_arbiter (
	input wire logic    clk,
	input wire logic    reset,
	chip_bus_if.arbiter cpu,
	chip_bus_if.arbiter dma,
	chip_bus_if.host    ram
);
	import chipset_pkg::*;

	arb_state_t state_q; // owner of the last granted cycle
	logic       pick_dma;
	logic       pick_cpu;
	logic       rd_dma_q; // outstanding read belongs to dma

	// dma wins unless it had the previous slot and the cpu is waiting
	assign pick_dma = dma.req && (!cpu.req || state_q != DMA_SLOT);
	assign pick_cpu = cpu.req && !pick_dma;

	assign dma.gnt = pick_dma;
	assign cpu.gnt = pick_cpu;

	// ----------------------------------------
	// forward the owner to ram
	assign ram.req   = dma.req || cpu.req;
	assign ram.gnt   = pick_dma || pick_cpu; // ram enable
	assign ram.addr  = pick_dma ? dma.addr : cpu.addr;
	assign ram.we    = pick_dma ? dma.we : cpu.we;
	assign ram.be    = pick_dma ? dma.be : cpu.be;
	assign ram.wdata = pick_dma ? dma.wdata : cpu.wdata;

	// read data back to whoever asked
	assign dma.rdata  = ram.rdata;
	assign cpu.rdata  = ram.rdata;
	assign dma.rvalid = ram.rvalid && rd_dma_q;
	assign cpu.rvalid = ram.rvalid && !rd_dma_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q  <= IDLE;
			rd_dma_q <= 1'b0;
		end else begin
			if (pick_dma)
				state_q <= DMA_SLOT;
			else if (pick_cpu)
				state_q <= CPU_SLOT;
			else
				state_q <= IDLE; // empty cycle
			rd_dma_q <= pick_dma && !dma.we;
		end
	end

endmodule

`default_nettype wire

/* chip_ram.sv */
/* synchronous chip ram with byte write enables
   accessed on the arbiter's grant cycle, read data one cycle later */
`timescale 1ns/1ps
`default_nettype none
`include "chipset_config.svh"

module chip_ram (
	input wire logic clk,
	chip_bus_if.ram  bus
);
	import chipset_pkg::*;

	word_t mem [2**`CHIP_AW]; // contents undefined until written

	always_ff @(posedge clk) begin
		if (bus.gnt) begin
			if (bus.we) begin
				if (bus.be[1]) mem[bus.addr][`DW-1:`DW/2] <= bus.wdata[`DW-1:`DW/2];
				if (bus.be[0]) mem[bus.addr][`DW/2-1:0] <= bus.wdata[`DW/2-1:0];
			end else begin
				bus.rdata <= mem[bus.addr];
			end
		end
		bus.rvalid <= bus.gnt && !bus.we; // read data ready next cycle
	end

endmodule

`default_nettype wire

/* custom_regs.sv */
/* custom register block with dma pointers, intena/intreq and level encoder
   written and read through the single-cycle register strobe of the cpu bridge */
`timescale 1ns/1ps
`default_nettype none
`include "chipset_config.svh"

module custom_regs (
	input  wire logic                   clk,
	input  wire logic                   reset,
	input  wire logic                   reg_sel_i, // one cycle per access
	input  wire logic                   reg_we_i,
	input  wire chipset_pkg::reg_addr_t reg_addr_i,
	input  wire chipset_pkg::word_t     reg_wdata_i,
	output chipset_pkg::word_t          reg_rdata_o,
	input  wire logic                   ext_int_i, // level
	dma_ctrl_if.regs                    dma,
	output chipset_pkg::ipl_t           cpu_ipl_o
);
	import chipset_pkg::*;

	chip_addr_t src_q, dst_q, len_q;
	int_bits_t  intena_q, intreq_q;
	logic       start_q;
	logic       wr;
	int_bits_t  wbits; // written bits without set-clr

	assign wr    = reg_sel_i && reg_we_i;
	assign wbits = reg_wdata_i[14:0];

	assign dma.src   = src_q;
	assign dma.dst   = dst_q;
	assign dma.len   = len_q;
	assign dma.start = start_q;

	// ----------------------------------------
	// register writes
	always_ff @(posedge clk) begin
		if (reset) begin
			intena_q <= '0;
			intreq_q <= '0;
			start_q  <= 1'b0;
		end else begin
			start_q <= wr && reg_addr_i == `REG_DMACON && reg_wdata_i[`DMA_START];
			if (wr && reg_addr_i == `REG_INTENA)
				intena_q <= reg_wdata_i[`INT_SETCLR] ? (intena_q | wbits) : (intena_q & ~wbits);
			if (wr && reg_addr_i == `REG_INTREQ)
				intreq_q <= reg_wdata_i[`INT_SETCLR] ? (intreq_q | wbits) : (intreq_q & ~wbits);
			if (dma.done) intreq_q[`INT_DMA] <= 1'b1; // hardware sources win
			if (ext_int_i) intreq_q[`INT_EXT2] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr && reg_addr_i == `REG_DMASRC) src_q <= reg_wdata_i[`CHIP_AW-1:0];
		if (wr && reg_addr_i == `REG_DMADST) dst_q <= reg_wdata_i[`CHIP_AW-1:0];
		if (wr && reg_addr_i == `REG_DMALEN) len_q <= reg_wdata_i[`CHIP_AW-1:0];
	end

	// read mux, unlisted offsets read 0
	always_comb begin
		case (reg_addr_i)
			`REG_DMASRC:  reg_rdata_o = word_t'(src_q);
			`REG_DMADST:  reg_rdata_o = word_t'(dst_q);
			`REG_DMALEN:  reg_rdata_o = word_t'(len_q);
			`REG_INTENAR: reg_rdata_o = {1'b0, intena_q};
			`REG_INTREQR: reg_rdata_o = {1'b0, intreq_q};
			default:      reg_rdata_o = '0;
		endcase
	end

	// level encoder, registered so it lags the registers by one clock
	always_ff @(posedge clk) begin
		if (reset)
			cpu_ipl_o <= '0;
		else if (!intena_q[`INT_MASTER])
			cpu_ipl_o <= '0;
		else if (intreq_q[`INT_DMA] && intena_q[`INT_DMA])
			cpu_ipl_o <= 3'd3;
		else if (intreq_q[`INT_EXT2] && intena_q[`INT_EXT2])
			cpu_ipl_o <= 3'd2;
		else
			cpu_ipl_o <= '0;
	end

endmodule

`default_nettype wire

/* chipset_top.sv */
/* top level of the chip-bus core with plain cpu pins
   ties the bridge, copy channel, arbiter, chip ram and custom registers */
`timescale 1ns/1ps
`default_nettype none

module chipset_top (
	input  wire logic                   clk,
	input  wire logic                   reset,
	input  wire logic                   cpu_as_i,
	input  wire logic                   cpu_we_i,
	input  wire chipset_pkg::cpu_addr_t cpu_addr_i,
	input  wire chipset_pkg::byte_en_t  cpu_be_i,
	input  wire chipset_pkg::word_t     cpu_wdata_i,
	input  wire logic                   ext_int_i,
	output chipset_pkg::word_t          cpu_rdata_o,
	output logic                        cpu_dtack_o,
	output chipset_pkg::ipl_t           cpu_ipl_o
);
	import chipset_pkg::*;

	chip_bus_if cpu_bus ();
	chip_bus_if dma_bus ();
	chip_bus_if ram_bus ();
	dma_ctrl_if dma_ctrl ();

	// register strobe path
	logic      reg_sel;
	logic      reg_we;
	reg_addr_t reg_addr;
	word_t     reg_wdata;
	word_t     reg_rdata;

	cpu_bridge u_cpu_bridge (
		.clk(clk), .reset(reset),
		.cpu_as_i(cpu_as_i), .cpu_we_i(cpu_we_i), .cpu_addr_i(cpu_addr_i),
		.cpu_be_i(cpu_be_i), .cpu_wdata_i(cpu_wdata_i),
		.cpu_rdata_o(cpu_rdata_o), .cpu_dtack_o(cpu_dtack_o),
		.bus(cpu_bus),
		.reg_sel_o(reg_sel), .reg_we_o(reg_we), .reg_addr_o(reg_addr),
		.reg_wdata_o(reg_wdata), .reg_rdata_i(reg_rdata)
	);

	blit_dma u_blit_dma (.clk(clk), .reset(reset), .ctrl(dma_ctrl), .bus(dma_bus));

	chip_arbiter u_chip_arbiter (
		.clk(clk), .reset(reset), .cpu(cpu_bus), .dma(dma_bus), .ram(ram_bus)
	);

	chip_ram u_chip_ram (.clk(clk), .bus(ram_bus));

	custom_regs u_custom_regs (
		.clk(clk), .reset(reset),
		.reg_sel_i(reg_sel), .reg_we_i(reg_we), .reg_addr_i(reg_addr),
		.reg_wdata_i(reg_wdata), .reg_rdata_o(reg_rdata),
		.ext_int_i(ext_int_i), .dma(dma_ctrl), .cpu_ipl_o(cpu_ipl_o)
	);

endmodule

`default_nettype wire

/* tb_chipset_top.sv */
/* testbench for the chip-bus core, drives 68k style cycles from a step table
   covers chip ram, interrupt registers, block copy and shared access */
`timescale 1ns/1ps
`default_nettype none
`include "chipset_config.svh"

module tb_chipset_top;
	import chipset_pkg::*;

	typedef enum logic [1:0] {OP_WR, OP_RD, OP_IPL, OP_IDLE} op_t;
	// idle step: addr is the cycle count, data[0] the ext_int_i level
	typedef struct packed {
		op_t       op;
		cpu_addr_t addr;
		word_t     data;
		byte_en_t  be;
		word_t     exp; // read data or ipl
	} entry_t;

	localparam int DTACK_LIMIT = 100;
	localparam int IPL_LIMIT   = 500; // covers a 16 word copy under cpu load
	localparam word_t SETCLR   = word_t'(1) << `INT_SETCLR;
	localparam word_t MASTER   = word_t'(1) << `INT_MASTER;
	localparam word_t DMA_BIT  = word_t'(1) << `INT_DMA;
	localparam word_t EXT2_BIT = word_t'(1) << `INT_EXT2;
	localparam word_t START    = word_t'(1) << `DMA_START;
	localparam chip_addr_t SRC = 12'h100, DST_A = 12'h200, DST_B = 12'h300;
	localparam chip_addr_t CPU_AREA = 12'h400, DST_Z = 12'h500;

	logic      clk = 1'b0;
	logic      reset, cpu_as_i, cpu_we_i, ext_int_i, cpu_dtack_o;
	cpu_addr_t cpu_addr_i;
	byte_en_t  cpu_be_i;
	word_t     cpu_wdata_i, cpu_rdata_o;
	ipl_t      cpu_ipl_o;

	entry_t steps[$];
	word_t  model [0:4095]; // expected chip ram contents
	int     seed;
	int     errors = 0;
	int     checks = 0;
	logic   table_ready = 1'b0;

	chipset_top dut (
		.clk(clk), .reset(reset), .cpu_as_i(cpu_as_i), .cpu_we_i(cpu_we_i),
		.cpu_addr_i(cpu_addr_i), .cpu_be_i(cpu_be_i), .cpu_wdata_i(cpu_wdata_i),
		.ext_int_i(ext_int_i), .cpu_rdata_o(cpu_rdata_o), .cpu_dtack_o(cpu_dtack_o),
		.cpu_ipl_o(cpu_ipl_o)
	);

	always #2 clk = ~clk; // 4 ns period

	// ----------------------------------------
	// table building, model follows every step
	function automatic cpu_addr_t reg_space(input reg_addr_t off);
		return {1'b1, {(`CPU_AW-4){1'b0}}, off};
	endfunction

	task automatic ram_write(input chip_addr_t a, input word_t d, input byte_en_t be);
		steps.push_back('{OP_WR, cpu_addr_t'(a), d, be, '0});
		if (be[1]) model[a][15:8] = d[15:8];
		if (be[0]) model[a][7:0] = d[7:0]; // other lane untouched
	endtask

	task automatic ram_read(input chip_addr_t a);
		steps.push_back('{OP_RD, cpu_addr_t'(a), '0, 2'b11, model[a]});
	endtask

	task automatic reg_write(input reg_addr_t off, input word_t d);
		steps.push_back('{OP_WR, reg_space(off), d, 2'b11, '0});
	endtask

	task automatic reg_read(input reg_addr_t off, input word_t exp);
		steps.push_back('{OP_RD, reg_space(off), '0, 2'b11, exp});
	endtask

	task automatic expect_ipl(input ipl_t level);
		steps.push_back('{OP_IPL, '0, '0, 2'b00, word_t'(level)});
	endtask

	task automatic pause(input int cycles, input logic ext);
		steps.push_back('{OP_IDLE, cpu_addr_t'(cycles), word_t'(ext), 2'b00, '0});
	endtask

	task automatic copy_in_model(input chip_addr_t s, input chip_addr_t d, input int n);
		for (int i = 0; i < n; i++)
			model[d + chip_addr_t'(i)] = model[s + chip_addr_t'(i)];
	endtask

	task automatic build_table();
		ram_write(12'h010, 16'h1234, 2'b11); // full words
		ram_write(12'h011, 16'habcd, 2'b11);
		ram_write(12'h010, 16'h56ff, 2'b10); // upper byte only
		ram_write(12'h011, 16'h00ef, 2'b01); // lower byte only
		ram_write(12'h012, 16'hffff, 2'b11);
		ram_write(12'h012, 16'h0000, 2'b00); // no lanes enabled
		ram_read(12'h010);
		ram_read(12'h011);
		ram_read(12'h012);
		// set and clear rules of intena / intreq
		reg_write(`REG_INTENA, SETCLR | MASTER | EXT2_BIT);
		reg_read(`REG_INTENAR, MASTER | EXT2_BIT);
		reg_write(`REG_INTREQ, SETCLR | 16'h0003); // two unencoded bits
		reg_read(`REG_INTREQR, 16'h0003);
		expect_ipl(3'd0); // no level from unencoded requests
		reg_write(`REG_INTREQ, 16'h0001);
		reg_read(`REG_INTREQR, 16'h0002);
		reg_write(`REG_INTREQ, 16'h0002);
		pause(4, 1'b1); // external request high
		expect_ipl(3'd2);
		pause(2, 1'b0);
		reg_read(`REG_INTREQR, EXT2_BIT); // request stays latched
		reg_write(`REG_INTREQ, EXT2_BIT);
		expect_ipl(3'd0);
		reg_write(`REG_INTENA, EXT2_BIT);
		reg_read(`REG_INTENAR, MASTER);
		// ----------------------------------------
		// block copy of random words
		reg_write(`REG_INTENA, SETCLR | DMA_BIT);
		for (int i = 0; i < 16; i++)
			ram_write(SRC + chip_addr_t'(i), word_t'($random(seed)), 2'b11);
		ram_write(DST_A + 12'd16, 16'h5a5a, 2'b11); // guard word past the block
		reg_write(`REG_DMASRC, word_t'(SRC));
		reg_write(`REG_DMADST, word_t'(DST_A));
		reg_write(`REG_DMALEN, 16'd16);
		reg_read(`REG_DMALEN, 16'd16);
		reg_write(`REG_DMACON, START);
		copy_in_model(SRC, DST_A, 16);
		expect_ipl(3'd3);
		for (int i = 0; i <= 16; i++)
			ram_read(DST_A + chip_addr_t'(i));
		reg_write(`REG_INTREQ, DMA_BIT);
		expect_ipl(3'd0);
		// second copy with cpu traffic elsewhere
		ram_write(DST_B + 12'd16, 16'ha5a5, 2'b11);
		reg_write(`REG_DMADST, word_t'(DST_B));
		reg_write(`REG_DMACON, START);
		copy_in_model(SRC, DST_B, 16);
		for (int i = 0; i < 8; i++) begin
			ram_write(CPU_AREA + chip_addr_t'(i), word_t'($random(seed)), 2'b11);
			ram_read(CPU_AREA + chip_addr_t'(i));
		end
		expect_ipl(3'd3);
		for (int i = 0; i <= 16; i++)
			ram_read(DST_B + chip_addr_t'(i));
		reg_write(`REG_INTREQ, DMA_BIT);
		expect_ipl(3'd0);
		// zero length start
		ram_write(DST_Z, 16'hc3c3, 2'b11);
		reg_write(`REG_DMADST, word_t'(DST_Z));
		reg_write(`REG_DMALEN, 16'd0);
		reg_write(`REG_DMACON, START);
		expect_ipl(3'd3);
		ram_read(DST_Z);
		ram_read(SRC);
		reg_write(`REG_INTREQ, DMA_BIT);
		expect_ipl(3'd0);
	endtask

	// ----------------------------------------
	// applying steps
	task automatic cpu_access(input entry_t e);
		int   cycles;
		logic seen;
		cycles = 0;
		seen = 1'b0;
		@(posedge clk);
		cpu_as_i    <= 1'b1;
		cpu_we_i    <= (e.op == OP_WR);
		cpu_addr_i  <= e.addr;
		cpu_be_i    <= e.be;
		cpu_wdata_i <= e.data;
		while (!seen && cycles < DTACK_LIMIT) begin
			@(posedge clk);
			cycles++;
			if (cpu_dtack_o === 1'b1) seen = 1'b1;
		end
		cpu_as_i <= 1'b0; // strobe drops after dtack
		checks++;
		if (!seen) begin
			$display("no dtack within %0d cycles for address %h at %0t", cycles, e.addr, $time);
			errors++;
		end else if (e.addr[`CPU_AW-1] && cycles != 2) begin
			$display("FAIL %0t: register access at %h took %0d cycles", $time, e.addr, cycles);
			errors++;
		end else if (e.op == OP_RD && cpu_rdata_o !== e.exp) begin
			$display("FAIL %0t: read %h gave %h, expected %h", $time, e.addr, cpu_rdata_o, e.exp);
			errors++;
		end
	endtask

	task automatic wait_ipl(input ipl_t level);
		int n;
		n = 0;
		while (cpu_ipl_o !== level && n < IPL_LIMIT) begin
			@(posedge clk);
			n++;
		end
		checks++;
		if (cpu_ipl_o !== level) begin
			$display("interrupt level %0d did not appear within %0d cycles at %0t", level, n, $time);
			errors++;
		end
	endtask

	task automatic apply_step(input entry_t e);
		case (e.op)
			OP_WR, OP_RD: cpu_access(e);
			OP_IPL:       wait_ipl(e.exp[2:0]);
			default: begin
				@(posedge clk);
				ext_int_i <= e.data[0];
				repeat (e.addr) @(posedge clk);
			end
		endcase
	endtask

	task automatic check_quiet(input string when);
		checks++;
		if (cpu_dtack_o !== 1'b0 || cpu_ipl_o !== 3'd0) begin
			$display("FAIL %0t: dtack %b ipl %0d %s", $time, cpu_dtack_o, cpu_ipl_o, when);
			errors++;
		end
	endtask

	// ----------------------------------------
	initial begin
		seed = 32'hc80b;
		reset       <= 1'b1;
		cpu_as_i    <= 1'b0;
		cpu_we_i    <= 1'b0;
		cpu_addr_i  <= '0;
		cpu_be_i    <= 2'b00;
		cpu_wdata_i <= '0;
		ext_int_i   <= 1'b0;
		build_table();
		table_ready = 1'b1;
		for (int i = 0; i < 16; i++) begin
			@(posedge clk);
			if (i > 0) check_quiet("during reset"); // first edge clears the flops
		end
		reset <= 1'b0;
		repeat (2) @(posedge clk);
		check_quiet("after reset");
		foreach (steps[k])
			apply_step(steps[k]);
		repeat (4) @(posedge clk);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// watchdog, 200 cycles per step
	initial begin
		wait (table_ready);
		repeat (steps.size() * 200) @(posedge clk);
		$display("watchdog expired, run took more than %0d cycles", steps.size() * 200);
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* chipset_top.f */
+incdir+.
chipset_pkg.sv
chip_bus_if.sv
cpu_bridge.sv
blit_dma.sv
chip_arbiter.sv
chip_ram.sv
custom_regs.sv
chipset_top.sv
tb_chipset_top.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it and pass only on the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_chipset_top -f chipset_top.f -o sim_chipset
out=$(./obj_dir/sim_chipset)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx 'Done: no errors'; then
	exit 0
fi
exit 1
